// ==== include/ringBus_settings.svh ====
/*
 ring bus sizing and address map
   slot field widths, memory stop depth and word indexing
   rom fill pattern
   range decode macros for rom, memory and mmio stops
*/
`ifndef RINGBUS_SETTINGS_SVH
`define RINGBUS_SETTINGS_SVH

`define RB_ADDR_W      32                      // ring address
`define RB_DATA_W      64                      // one tile per slot
`define RB_SEQ_W       16
`define RB_OPM_W       16                      // flag byte plus opcode byte

`define RB_MEM_WORDS   256                     // memory stop backing store
`define RB_MEM_IDX_W   8
`define RB_WORD_LSB    3                       // 64-bit words
`define RB_ROM_IDX_HI  23                      // rom index runs up to here

`define RB_ROM_PATTERN 64'h5A3C_96E1_0F78_C2B4

// top byte zero
`define RB_IS_ROM(a)  (a[`RB_ADDR_W-1 -: 8] == 8'h00)
// top nibble zero, next nibble set
`define RB_IS_MEM(a)  ((a[`RB_ADDR_W-1 -: 4] == 4'h0) && (a[`RB_ADDR_W-5 -: 4] != 4'h0))
`define RB_IS_MMIO(a) (a[`RB_ADDR_W-1 -: 4] == 4'hF)

`endif

// ==== hdl/ringBusPkg.sv ====
/*
 ring bus package
   opcode classes, request commands and response status codes
   full 8-bit opcodes for both directions
   operation-mode word with request and response views
   mmio device opcodes and handshake codes
*/
package ringBusPkg;

	// class sits in opm[7:6]
	localparam logic [1:0] CLS_NONE = 2'b00;
	localparam logic [1:0] CLS_RESP = 2'b01;
	localparam logic [1:0] CLS_REQ  = 2'b10;

	localparam logic [5:0] CMD_LDX  = 6'h03;   // load tile
	localparam logic [5:0] CMD_STX  = 6'h13;   // store tile

	localparam logic [5:0] ST_OKLD  = 6'h03;
	localparam logic [5:0] ST_OKST  = 6'h13;
	localparam logic [5:0] ST_FAULT = 6'h3F;

	localparam logic [7:0] OPM_NONE  = 8'h00;  // empty slot
	localparam logic [7:0] OPM_LDX   = {CLS_REQ, CMD_LDX};
	localparam logic [7:0] OPM_STX   = {CLS_REQ, CMD_STX};
	localparam logic [7:0] OPM_OKLD  = {CLS_RESP, ST_OKLD};
	localparam logic [7:0] OPM_OKST  = {CLS_RESP, ST_OKST};
	localparam logic [7:0] OPM_FAULT = {CLS_RESP, ST_FAULT};

	// outside device port
	localparam logic [4:0] MMIO_OPM_NONE = 5'h00;
	localparam logic [4:0] MMIO_OPM_LD   = 5'h0B;
	localparam logic [4:0] MMIO_OPM_ST   = 5'h17;

	localparam logic [1:0] MMIO_OK_READY = 2'b00;
	localparam logic [1:0] MMIO_OK_HOLD  = 2'b10;
	localparam logic [1:0] MMIO_OK_DONE  = 2'b01;
	localparam logic [1:0] MMIO_OK_FAIL  = 2'b11;

	typedef struct packed {
		logic [7:0] flags;                   // carried through untouched
		logic [1:0] cls;
		logic [5:0] cmd;
	} ringOpmReq_t;

	typedef struct packed {
		logic [7:0] flags;
		logic [1:0] cls;
		logic [5:0] status;
	} ringOpmRsp_t;

	// same 16 bits, read as request on the way in, written as response on the way out
	typedef union packed {
		ringOpmReq_t req;
		ringOpmRsp_t rsp;
	} ringOpm_u;

endpackage

// ==== hdl/ringMemStop.sv ====
/*
 memory ring stop
   ram backing store in place of the l2 data array
   loads and stores in the memory range answered in the same slot
   everything else registered through
*/
`timescale 1ns/1ps
`include "ringBus_settings.svh"

module ringMemStop
	import ringBusPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic [`RB_SEQ_W-1:0]  seqIn,
	input  logic [`RB_OPM_W-1:0]  opmIn,
	input  logic [`RB_ADDR_W-1:0] addrIn,
	input  logic [`RB_DATA_W-1:0] dataIn,
	output logic [`RB_SEQ_W-1:0]  seqOut,
	output logic [`RB_OPM_W-1:0]  opmOut,
	output logic [`RB_ADDR_W-1:0] addrOut,
	output logic [`RB_DATA_W-1:0] dataOut
);

	ringOpm_u opmReq;                         // incoming word, request view
	ringOpm_u opmNext;                        // what leaves this stage
	logic inRange;
	logic isLoad;
	logic isStore;
	logic [`RB_MEM_IDX_W-1:0] memIdx;

	logic [`RB_DATA_W-1:0] memArray [`RB_MEM_WORDS];

	assign opmReq  = opmIn;
	assign inRange = `RB_IS_MEM(addrIn);
	assign memIdx  = addrIn[`RB_WORD_LSB +: `RB_MEM_IDX_W];   // word index

	assign isLoad  = inRange && (opmReq.req.cls == CLS_REQ) && (opmReq.req.cmd == CMD_LDX);
	assign isStore = inRange && (opmReq.req.cls == CLS_REQ) && (opmReq.req.cmd == CMD_STX);

	// build the answer in response view
	always_comb
	begin
		opmNext = opmIn;                      // pass through by default
		if (isLoad || isStore)
		begin
			opmNext.rsp.cls    = CLS_RESP;    // flags stay as sent
			opmNext.rsp.status = isStore ? ST_OKST : ST_OKLD;
		end
	end

	// backing store
	always_ff @(posedge clock)
	begin
		if (isStore)
			memArray[memIdx] <= dataIn;
	end

	// one register stage
	always_ff @(posedge clock)
	begin
		seqOut  <= seqIn;                     // seq and address kept
		addrOut <= addrIn;
		if (isLoad)
			dataOut <= memArray[memIdx];
		else if (isStore)
			dataOut <= '0;                    // stores answer with zero
		else
			dataOut <= dataIn;

		if (reset)
			opmOut <= '0;                     // empty slot
		else
			opmOut <= opmNext;
	end

endmodule

// ==== hdl/ringRomStop.sv ====
/*
 rom ring stop
   loads in the rom range return index xor fill pattern
   stores in the rom range fault
   other slots registered through
*/
`timescale 1ns/1ps
`include "ringBus_settings.svh"

module ringRomStop
	import ringBusPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic [`RB_SEQ_W-1:0]  seqIn,
	input  logic [`RB_OPM_W-1:0]  opmIn,
	input  logic [`RB_ADDR_W-1:0] addrIn,
	input  logic [`RB_DATA_W-1:0] dataIn,
	output logic [`RB_SEQ_W-1:0]  seqOut,
	output logic [`RB_OPM_W-1:0]  opmOut,
	output logic [`RB_ADDR_W-1:0] addrOut,
	output logic [`RB_DATA_W-1:0] dataOut
);

	localparam int IdxW = `RB_ROM_IDX_HI - `RB_WORD_LSB + 1;

	ringOpm_u opmReq;
	ringOpm_u opmNext;
	logic inRange;
	logic isLoad;
	logic isStore;
	logic [IdxW-1:0] romIdx;
	logic [`RB_DATA_W-1:0] romWord;

	assign opmReq  = opmIn;
	assign inRange = `RB_IS_ROM(addrIn);
	assign isLoad  = inRange && (opmReq.req.cls == CLS_REQ) && (opmReq.req.cmd == CMD_LDX);
	assign isStore = inRange && (opmReq.req.cls == CLS_REQ) && (opmReq.req.cmd == CMD_STX);

	// contents computed, no table
	assign romIdx  = addrIn[`RB_ROM_IDX_HI:`RB_WORD_LSB];
	assign romWord = {{(`RB_DATA_W - IdxW){1'b0}}, romIdx} ^ `RB_ROM_PATTERN;

	always_comb
	begin
		opmNext = opmIn;
		if (isLoad || isStore)
		begin
			opmNext.rsp.cls    = CLS_RESP;
			opmNext.rsp.status = isStore ? ST_FAULT : ST_OKLD;   // read only
		end
	end

	always_ff @(posedge clock)
	begin
		seqOut  <= seqIn;
		addrOut <= addrIn;
		if (isLoad)
			dataOut <= romWord;
		else if (isStore)
			dataOut <= '0;
		else
			dataOut <= dataIn;

		if (reset)
			opmOut <= '0;
		else
			opmOut <= opmNext;
	end

endmodule

// ==== hdl/ringMmioStop.sv ====
/*
 mmio ring stop
   takes one mmio-range request off the ring at a time
   runs the device exchange on the outside port
   holds the answer until an empty slot comes by
*/
`timescale 1ns/1ps
`include "ringBus_settings.svh"

module ringMmioStop
	import ringBusPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic [`RB_SEQ_W-1:0]  seqIn,
	input  logic [`RB_OPM_W-1:0]  opmIn,
	input  logic [`RB_ADDR_W-1:0] addrIn,
	input  logic [`RB_DATA_W-1:0] dataIn,
	output logic [`RB_SEQ_W-1:0]  seqOut,
	output logic [`RB_OPM_W-1:0]  opmOut,
	output logic [`RB_ADDR_W-1:0] addrOut,
	output logic [`RB_DATA_W-1:0] dataOut,
	output logic [`RB_ADDR_W-1:0] mmioAddr,
	output logic [4:0]            mmioOpm,
	output logic [`RB_DATA_W-1:0] mmioOutData,
	input  logic [`RB_DATA_W-1:0] mmioInData,
	input  logic [1:0]            mmioOK
);

	localparam logic [1:0] stIdle  = 2'd0;
	localparam logic [1:0] stIssue = 2'd1;   // device opcode on the port
	localparam logic [1:0] stDrain = 2'd2;   // waiting for mmioOK to go idle
	localparam logic [1:0] stHold  = 2'd3;   // answer still looking for a slot

	logic [1:0] state;
	ringOpm_u opmReq;                         // incoming word in request view
	ringOpm_u opmRsp;                         // held answer in response view
	logic isReq;
	logic take;                               // pull request off the ring
	logic slotFree;
	logic insert;                             // drop answer into this slot
	logic devFinished;
	logic rspPending;
	logic heldStore;
	logic heldFault;
	logic [7:0] heldFlags;
	logic [`RB_SEQ_W-1:0] heldSeq;
	logic [`RB_ADDR_W-1:0] heldAddr;
	logic [`RB_DATA_W-1:0] heldWData;         // store data to device
	logic [`RB_DATA_W-1:0] heldRData;         // answer data

	assign opmReq = opmIn;
	assign isReq  = `RB_IS_MMIO(addrIn) && (opmReq.req.cls == CLS_REQ)
		&& ((opmReq.req.cmd == CMD_LDX) || (opmReq.req.cmd == CMD_STX));
	assign take     = (state == stIdle) && isReq;   // busy means pass through
	assign slotFree = (opmIn[7:0] == OPM_NONE);
	assign insert   = rspPending && slotFree;
	assign devFinished = (mmioOK == MMIO_OK_DONE) || (mmioOK == MMIO_OK_FAIL);

	// device port
	assign mmioAddr    = heldAddr;
	assign mmioOutData = heldWData;
	assign mmioOpm     = (state != stIssue) ? MMIO_OPM_NONE :
		(heldStore ? MMIO_OPM_ST : MMIO_OPM_LD);

	always_comb
	begin
		opmRsp.rsp.flags = heldFlags;
		opmRsp.rsp.cls   = CLS_RESP;
		if (heldFault)
			opmRsp.rsp.status = ST_FAULT;     // device said fail
		else if (heldStore)
			opmRsp.rsp.status = ST_OKST;
		else
			opmRsp.rsp.status = ST_OKLD;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state      <= stIdle;
			rspPending <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
					if (take)
						state <= stIssue;
				stIssue:
					if (devFinished)
					begin
						state      <= stDrain;
						rspPending <= 1'b1;
					end
				stDrain:                      // answer may leave while draining
					if (mmioOK == MMIO_OK_READY)
						state <= (rspPending && !insert) ? stHold : stIdle;
				stHold:
					if (insert)
						state <= stIdle;
				default:
					state <= stIdle;
			endcase
			if (insert)
				rspPending <= 1'b0;
		end
	end

	// request and answer capture
	always_ff @(posedge clock)
	begin
		if (take)
		begin
			heldSeq   <= seqIn;
			heldAddr  <= addrIn;
			heldWData <= dataIn;
			heldFlags <= opmReq.req.flags;
			heldStore <= (opmReq.req.cmd == CMD_STX);
		end
		if ((state == stIssue) && devFinished)
		begin
			heldFault <= (mmioOK == MMIO_OK_FAIL);
			if (heldStore || (mmioOK == MMIO_OK_FAIL))
				heldRData <= '0;
			else
				heldRData <= mmioInData;
		end
	end

	// ring register stage
	always_ff @(posedge clock)
	begin
		seqOut  <= insert ? heldSeq : seqIn;
		addrOut <= insert ? heldAddr : addrIn;
		dataOut <= insert ? heldRData : dataIn;

		if (reset)
			opmOut <= '0;
		else if (insert)
			opmOut <= opmRsp;
		else if (take)
			opmOut <= '0;                     // slot goes empty
		else
			opmOut <= opmIn;
	end

endmodule

// ==== hdl/ringL2Hub.sv ====
/*
 l2 ring hub top
   chain of memory, rom and mmio stops
   response shortcut from the memory stop to the hub output
*/
`timescale 1ns/1ps
`include "ringBus_settings.svh"

module ringL2Hub
	import ringBusPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic [`RB_SEQ_W-1:0]  seqIn,
	input  logic [`RB_OPM_W-1:0]  opmIn,
	input  logic [`RB_ADDR_W-1:0] addrIn,
	input  logic [`RB_DATA_W-1:0] dataIn,
	output logic [`RB_SEQ_W-1:0]  seqOut,
	output logic [`RB_OPM_W-1:0]  opmOut,
	output logic [`RB_ADDR_W-1:0] addrOut,
	output logic [`RB_DATA_W-1:0] dataOut,
	output logic [`RB_ADDR_W-1:0] mmioAddr,
	output logic [4:0]            mmioOpm,
	output logic [`RB_DATA_W-1:0] mmioOutData,
	input  logic [`RB_DATA_W-1:0] mmioInData,
	input  logic [1:0]            mmioOK
);

	// memory stop out
	logic [`RB_SEQ_W-1:0]  memSeq;
	logic [`RB_OPM_W-1:0]  memOpm;
	logic [`RB_ADDR_W-1:0] memAddr;
	logic [`RB_DATA_W-1:0] memData;
	// rom stop in and out
	logic [`RB_SEQ_W-1:0]  romSeqIn, romSeq;
	logic [`RB_OPM_W-1:0]  romOpmIn, romOpm;
	logic [`RB_ADDR_W-1:0] romAddrIn, romAddr;
	logic [`RB_DATA_W-1:0] romDataIn, romData;
	// mmio stop out
	logic [`RB_SEQ_W-1:0]  ioSeq;
	logic [`RB_OPM_W-1:0]  ioOpm;
	logic [`RB_ADDR_W-1:0] ioAddr;
	logic [`RB_DATA_W-1:0] ioData;

	ringOpm_u memOpmView;
	logic bypass;

	ringMemStop u_memStop (
		.clock(clock), .reset(reset),
		.seqIn(seqIn), .opmIn(opmIn), .addrIn(addrIn), .dataIn(dataIn),
		.seqOut(memSeq), .opmOut(memOpm), .addrOut(memAddr), .dataOut(memData)
	);

	ringRomStop u_romStop (
		.clock(clock), .reset(reset),
		.seqIn(romSeqIn), .opmIn(romOpmIn), .addrIn(romAddrIn), .dataIn(romDataIn),
		.seqOut(romSeq), .opmOut(romOpm), .addrOut(romAddr), .dataOut(romData)
	);

	ringMmioStop u_mmioStop (
		.clock(clock), .reset(reset),
		.seqIn(romSeq), .opmIn(romOpm), .addrIn(romAddr), .dataIn(romData),
		.seqOut(ioSeq), .opmOut(ioOpm), .addrOut(ioAddr), .dataOut(ioData),
		.mmioAddr(mmioAddr), .mmioOpm(mmioOpm), .mmioOutData(mmioOutData),
		.mmioInData(mmioInData), .mmioOK(mmioOK)
	);

	assign memOpmView = memOpm;

	// hole at the output and a finished memory answer waiting
	assign bypass = (ioOpm[7:0] == OPM_NONE) && (memOpmView.rsp.cls == CLS_RESP);

	always_comb
	begin
		// normal chain
		romSeqIn  = memSeq;
		romOpmIn  = memOpm;
		romAddrIn = memAddr;
		romDataIn = memData;
		seqOut    = ioSeq;
		opmOut    = ioOpm;
		addrOut   = ioAddr;
		dataOut   = ioData;

		if (bypass)
		begin
			// swap slots, empty one goes on round the ring
			romSeqIn  = ioSeq;
			romOpmIn  = ioOpm;
			romAddrIn = ioAddr;
			romDataIn = ioData;
			seqOut    = memSeq;
			opmOut    = memOpm;
			addrOut   = memAddr;
			dataOut   = memData;
		end
	end

endmodule

// ==== verif/ringL2Checker.sv ====
/*
 scoreboard for the l2 ring hub
   reference model of memory, rom and mmio device contents
   expected answer and latency class per seq
   output and device port comparison
*/
`timescale 1ns/1ps
`include "ringBus_settings.svh"

module ringL2Checker
	import ringBusPkg::*;
(
	input logic                  clock,
	input logic                  reset,
	input logic [`RB_SEQ_W-1:0]  seqIn,
	input logic [`RB_OPM_W-1:0]  opmIn,
	input logic [`RB_ADDR_W-1:0] addrIn,
	input logic [`RB_DATA_W-1:0] dataIn,
	input logic [`RB_SEQ_W-1:0]  seqOut,
	input logic [`RB_OPM_W-1:0]  opmOut,
	input logic [`RB_ADDR_W-1:0] addrOut,
	input logic [`RB_DATA_W-1:0] dataOut,
	input logic [`RB_ADDR_W-1:0] mmioAddr,
	input logic [4:0]            mmioOpm,
	input logic [`RB_DATA_W-1:0] mmioOutData
);

	localparam int LatFixed = 0;              // exactly 3 cycles
	localparam int LatShort = 1;              // 1 with the shortcut, else 3
	localparam int LatAny   = 2;              // paced by the device
	localparam int TabSize  = 4096;

	int valErrors   = 0;
	int otherErrors = 0;
	int outstanding = 0;                      // requests still waiting
	longint cycle   = 0;

	logic [1:0]  seqState [TabSize];          // 0 unused, 1 waiting, 2 answered
	logic [15:0] expOpm [TabSize];
	logic [31:0] expAddr [TabSize];
	logic [63:0] expData [TabSize];
	int          expLat [TabSize];
	longint      inCycle [TabSize];

	logic [63:0] memModel [256];
	logic [63:0] devModel [16];               // device register file copy

	logic        ioExpValid = 1'b0;           // one mmio request in flight
	logic [15:0] ioExpSeq;
	logic [4:0]  ioExpOpm;
	logic [31:0] ioExpAddr;
	logic [63:0] ioExpData;

	initial
	begin
		for (int i = 0; i < TabSize; i++)
			seqState[i] = 2'd0;
		for (int i = 0; i < 16; i++)
			devModel[i] = 64'h0;
	end

	// expected answer for one slot with models updated in arrival order
	function automatic void refModel(input logic [15:0] opm, input logic [31:0] addr,
		input logic [63:0] data, output logic [15:0] eOpm, output logic [63:0] eData,
		output int lat);
		logic isLd;
		logic isSt;
		isLd  = (opm[7:0] == OPM_LDX);
		isSt  = (opm[7:0] == OPM_STX);
		eOpm  = opm;                          // unserved slots come out as sent
		eData = data;
		lat   = (opm[7:6] == CLS_RESP) ? LatShort : LatFixed;
		if (isLd || isSt)
		begin
			if (addr[31:24] == 8'h00)
			begin
				eOpm[7:0] = isSt ? OPM_FAULT : OPM_OKLD;   // rom is read only
				eData     = isSt ? 64'h0 : ({43'd0, addr[23:3]} ^ `RB_ROM_PATTERN);
			end
			else if (addr[31:28] == 4'h0)
			begin
				lat       = LatShort;
				eOpm[7:0] = isSt ? OPM_OKST : OPM_OKLD;
				eData     = isSt ? 64'h0 : memModel[addr[10:3]];
				if (isSt)
					memModel[addr[10:3]] = data;
			end
			else if (addr[31:28] == 4'hF)
			begin
				lat = LatAny;
				if (addr[8])                  // device refuses these
				begin
					eOpm[7:0] = OPM_FAULT;
					eData     = 64'h0;
				end
				else
				begin
					eOpm[7:0] = isSt ? OPM_OKST : OPM_OKLD;
					eData     = isSt ? 64'h0 : devModel[addr[6:3]];
					if (isSt)
						devModel[addr[6:3]] = data;
				end
			end
		end
	endfunction

	task automatic reportValue(input string name, input logic [63:0] expV, input logic [63:0] gotV);
		$display("FAIL t=%0t %s expected %0h got %0h", $time, name, expV, gotV);
		valErrors++;
	endtask

	task automatic reportProblem(input string what);
		$display("ERROR t=%0t %s", $time, what);
		otherErrors++;
	endtask

	task automatic checkOutput();
		int idx;
		longint lat;
		idx = seqOut[11:0];
		if (seqState[idx] == 2'd0)
			reportProblem($sformatf("slot with seq %0d came out but was never sent", seqOut));
		else if (seqState[idx] == 2'd2)
			reportProblem($sformatf("second response for seq %0d", seqOut));
		else
		begin
			if (opmOut !== expOpm[idx])
				reportValue("opmOut", expOpm[idx], opmOut);
			if (addrOut !== expAddr[idx])
				reportValue("addrOut", expAddr[idx], addrOut);
			if (dataOut !== expData[idx])
				reportValue("dataOut", expData[idx], dataOut);
			lat = cycle - inCycle[idx];
			if ((expLat[idx] == LatFixed) && (lat != 3))
				reportProblem($sformatf("seq %0d took %0d cycles instead of 3", seqOut, lat));
			else if ((expLat[idx] == LatShort) && (lat != 1) && (lat != 3))
				reportProblem($sformatf("seq %0d took %0d cycles, not 1 or 3", seqOut, lat));
			seqState[idx] = 2'd2;
			outstanding--;
			if (ioExpValid && (seqOut == ioExpSeq))
				ioExpValid = 1'b0;            // device exchange over
		end
	endtask

	task automatic recordInput();
		int idx;
		int lat;
		logic [15:0] eOpm;
		logic [63:0] eData;
		idx = seqIn[11:0];
		refModel(opmIn, addrIn, dataIn, eOpm, eData, lat);
		expOpm[idx]   = eOpm;
		expAddr[idx]  = addrIn;
		expData[idx]  = eData;
		expLat[idx]   = lat;
		inCycle[idx]  = cycle;
		seqState[idx] = 2'd1;
		outstanding++;
		if (lat == LatAny)
		begin
			ioExpValid = 1'b1;
			ioExpSeq   = seqIn;
			ioExpOpm   = (opmIn[7:0] == OPM_STX) ? MMIO_OPM_ST : MMIO_OPM_LD;
			ioExpAddr  = addrIn;
			ioExpData  = dataIn;
		end
	endtask

	// lists the requests still waiting when the run times out
	task automatic reportMissing();
		int i;
		for (i = 0; i < TabSize; i++)
			if (seqState[i] == 2'd1)
				reportProblem($sformatf("no response ever came for seq %0d", i));
	endtask

	// ring and device port have settled by the falling edge
	always @(negedge clock)
	begin
		if (reset)
		begin
			if (opmOut !== '0)
				reportValue("opmOut", 64'h0, opmOut);
			if (mmioOpm !== '0)
				reportValue("mmioOpm", 64'h0, mmioOpm);
		end
		else
		begin
			cycle++;
			if (opmOut[7:0] != OPM_NONE)
				checkOutput();
			if (mmioOpm != MMIO_OPM_NONE)
			begin
				if (!ioExpValid)
					reportProblem("device port driven with no MMIO request in flight");
				else
				begin
					if (mmioOpm !== ioExpOpm)
						reportValue("mmioOpm", ioExpOpm, mmioOpm);
					if (mmioAddr !== ioExpAddr)
						reportValue("mmioAddr", ioExpAddr, mmioAddr);
					if (mmioOutData !== ioExpData)
						reportValue("mmioOutData", ioExpData, mmioOutData);
				end
			end
			if (opmIn[7:0] != OPM_NONE)
				recordInput();
		end
	end

endmodule

// ==== verif/ringL2HubTb.sv ====
/*
 testbench for the l2 ring hub
   clock, reset and slot stimulus for memory, rom, mmio and pass-through
   mmio device model with random hold time
   xorshift generator and run timeout
*/
`timescale 1ns/1ps
`include "ringBus_settings.svh"

module ringL2HubTb
	import ringBusPkg::*;
();

	localparam int MemWords   = 16;          // words touched by memory traffic
	localparam int RomOps     = 12;
	localparam int MmioOps    = 8;
	localparam int PassOps    = 8;
	localparam int RandSlots  = 200;
	localparam int NumReq     = 2 * MemWords + RomOps + MmioOps + PassOps + RandSlots;
	localparam int CycleLimit = NumReq * 40;

	logic                  clock;
	logic                  reset;
	logic [`RB_SEQ_W-1:0]  seqIn, seqOut;
	logic [`RB_OPM_W-1:0]  opmIn, opmOut;
	logic [`RB_ADDR_W-1:0] addrIn, addrOut, mmioAddr;
	logic [`RB_DATA_W-1:0] dataIn, dataOut, mmioOutData, mmioInData;
	logic [4:0]            mmioOpm;
	logic [1:0]            mmioOK;

	logic [15:0] nextSeq;
	logic [31:0] stimRng;
	logic [31:0] devRng;                      // own stream for the device
	logic [63:0] devRegs [16];
	int          holdLeft;
	logic        mmioWait;                    // an mmio answer is still owed
	logic [15:0] mmioSeq;

	ringL2Hub u_dut (.*);
	ringL2Checker u_chk (.*);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] nextRand();
		stimRng = xorshift(stimRng);
		return stimRng;
	endfunction

	function automatic logic [31:0] mmioAddrOf(input logic [3:0] idx, input logic fail);
		return {20'hF0000, 3'b000, fail, 1'b0, idx, 3'b000};   // bit 8 makes the device fail
	endfunction

	// one slot per cycle driven 1 ns after the edge
	task automatic sendSlot(input logic [15:0] opm, input logic [31:0] addr, input logic [63:0] data);
		@(posedge clock);
		#1;
		seqIn  = nextSeq;
		opmIn  = opm;
		addrIn = addr;
		dataIn = data;
		if (opm[7:0] != OPM_NONE)
			nextSeq = nextSeq + 16'd1;
	endtask

	task automatic sendMmio(input logic [15:0] opm, input logic [31:0] addr, input logic [63:0] data);
		mmioSeq  = nextSeq;
		mmioWait = 1'b1;
		sendSlot(opm, addr, data);
		while (mmioWait)
			sendSlot(16'h0, 32'h0, 64'h0);    // empty slots to carry the answer
	endtask

	always @(negedge clock)
		if (mmioWait && (opmOut[7:0] != OPM_NONE) && (seqOut == mmioSeq))
			mmioWait = 1'b0;

	// device side acting just after each edge
	always @(posedge clock)
	begin
		#1;
		if (reset)
			mmioOK = MMIO_OK_READY;
		else
			case (mmioOK)
				MMIO_OK_READY:
					if (mmioOpm != MMIO_OPM_NONE)
					begin
						devRng   = xorshift(devRng);
						holdLeft = devRng[1:0];   // 1 to 4 hold cycles
						mmioOK   = MMIO_OK_HOLD;
					end
				MMIO_OK_HOLD:
					if (holdLeft != 0)
						holdLeft--;
					else if (mmioAddr[8])
						mmioOK = MMIO_OK_FAIL;
					else
					begin
						if (mmioOpm == MMIO_OPM_ST)
							devRegs[mmioAddr[6:3]] = mmioOutData;
						else
							mmioInData = devRegs[mmioAddr[6:3]];
						mmioOK = MMIO_OK_DONE;
					end
				default:
					if (mmioOpm == MMIO_OPM_NONE)
						mmioOK = MMIO_OK_READY;   // stop let go so back to idle
			endcase
	end

	task automatic memTests();
		int i;
		for (i = 0; i < MemWords; i++)
			sendSlot({8'h00, OPM_STX}, 32'h0100_0000 + i * 8, {nextRand(), nextRand()});
		for (i = 0; i < MemWords; i++)
		begin
			sendSlot({8'h3C, OPM_LDX}, 32'h0100_0000 + (MemWords - 1 - i) * 8, 64'h0);
			if (i % 4 == 3)
				sendSlot(16'h0, 32'h0, 64'h0);
		end
	endtask

	task automatic romTests();
		int i;
		logic [31:0] r;
		for (i = 0; i < RomOps; i++)
		begin
			r = nextRand();
			sendSlot({8'hA5, (i % 3 == 2) ? OPM_STX : OPM_LDX}, {8'h00, r[23:0]}, {r, r});
		end
	endtask

	task automatic mmioTests();
		sendMmio({8'h11, OPM_STX}, mmioAddrOf(4'd1, 1'b0), 64'h0123_4567_89AB_CDEF);
		sendMmio({8'h12, OPM_STX}, mmioAddrOf(4'd2, 1'b0), {nextRand(), nextRand()});
		sendMmio({8'h13, OPM_LDX}, mmioAddrOf(4'd1, 1'b0), 64'h0);
		sendMmio({8'h14, OPM_LDX}, mmioAddrOf(4'd2, 1'b0), 64'h0);
		sendMmio({8'h15, OPM_STX}, mmioAddrOf(4'd1, 1'b1), 64'hDEAD_BEEF_0000_FFFF);
		sendMmio({8'h16, OPM_LDX}, mmioAddrOf(4'd2, 1'b1), 64'h0);
		sendMmio({8'h17, OPM_LDX}, mmioAddrOf(4'd1, 1'b0), 64'h0);   // refused store left it
		sendMmio({8'h18, OPM_LDX}, mmioAddrOf(4'd7, 1'b0), 64'h0);   // never written
	endtask

	task automatic passTests();
		sendSlot({8'h21, OPM_LDX}, 32'h5000_0040, 64'h1);           // unmapped requests
		sendSlot({8'h22, OPM_STX}, 32'h9ABC_0008, 64'hFFFF_0000_FFFF_0000);
		sendSlot({8'h23, OPM_LDX}, 32'hE000_0000, 64'h0);
		sendSlot({8'h24, OPM_STX}, 32'h1000_0000, 64'h5555_AAAA_5555_AAAA);
		sendSlot({8'h31, OPM_OKLD}, 32'h0100_0008, 64'h1111_2222_3333_4444);   // stray answers
		sendSlot({8'h32, OPM_OKST}, 32'h0000_0010, 64'h0);
		sendSlot({8'h33, OPM_FAULT}, mmioAddrOf(4'd3, 1'b0), 64'h7);
		sendSlot({8'h34, OPM_OKLD}, 32'h7777_0000, 64'h8);
	endtask

	task automatic randomTraffic();
		int i;
		logic [31:0] r;
		logic [63:0] d;
		logic [7:0] op;
		for (i = 0; i < RandSlots; i++)
		begin
			r  = nextRand();
			d  = {nextRand(), nextRand()};
			op = r[3] ? OPM_STX : OPM_LDX;
			case (r[2:0])
				3'd0, 3'd1:
					sendSlot({r[31:24], op}, 32'h0100_0000 + {r[7:4], 3'b000}, d);
				3'd2:
					sendSlot({r[31:24], op}, {8'h00, d[23:0]}, d);
				3'd3:
					if (!mmioWait)
					begin
						mmioSeq  = nextSeq;
						mmioWait = 1'b1;
						sendSlot({r[31:24], op}, mmioAddrOf(r[7:4], r[9]), d);
					end
					else
						sendSlot(16'h0, 32'h0, 64'h0);   // one mmio at a time
				3'd4:
					sendSlot({r[31:24], op}, {4'h5, d[27:0]}, d);
				3'd5:
					sendSlot({r[31:24], r[11] ? OPM_OKLD : OPM_FAULT}, d[63:32], d);
				default:
					sendSlot({r[31:24], OPM_NONE}, d[31:0], d);   // hole carrying only flags
			endcase
		end
	endtask

	initial
	begin
		repeat (CycleLimit) @(posedge clock);
		$display("ERROR run still busy after %0d cycles, responses missing", CycleLimit);
		u_chk.reportMissing();
		$display("errors: %0d value, %0d other", u_chk.valErrors, u_chk.otherErrors);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		reset      = 1'b1;
		seqIn      = '0;
		opmIn      = '0;
		addrIn     = '0;
		dataIn     = '0;
		mmioInData = '0;
		mmioOK     = MMIO_OK_READY;
		nextSeq    = 16'd1;
		stimRng    = 32'h40a7_c03f;
		devRng     = ~32'h40a7_c03f;
		mmioWait   = 1'b0;
		mmioSeq    = '0;
		holdLeft   = 0;
		for (int i = 0; i < 16; i++)
			devRegs[i] = 64'h0;
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;

		memTests();
		romTests();
		mmioTests();
		passTests();
		randomTraffic();
		while (u_chk.outstanding != 0)
			sendSlot(16'h0, 32'h0, 64'h0);
		repeat (8) sendSlot(16'h0, 32'h0, 64'h0);   // catch late duplicates

		$display("errors: %0d value, %0d other", u_chk.valErrors, u_chk.otherErrors);
		if (u_chk.valErrors + u_chk.otherErrors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/ringBusPkg.sv
hdl/ringMemStop.sv
hdl/ringRomStop.sv
hdl/ringMmioStop.sv
hdl/ringL2Hub.sv
verif/ringL2Checker.sv
verif/ringL2HubTb.sv

// ==== Bender.yml ====
package:
  name: ring_l2_hub

sources:
  - include_dirs:
      - include
    files:
      - hdl/ringBusPkg.sv
      - hdl/ringMemStop.sv
      - hdl/ringRomStop.sv
      - hdl/ringMmioStop.sv
      - hdl/ringL2Hub.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/ringL2Checker.sv
      - verif/ringL2HubTb.sv
